// File: Makefile
# Verilator simulation of the keyboard scale player

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
	./obj_dir/tb_top_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "test passed" || \
		(echo "test failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+hw
hw/tone_pkg.sv
hw/ps2_receiver.sv
hw/key_event_fifo.sv
hw/scale_stepper.sv
hw/tone_pwm.sv
hw/keyboard_tone_top.sv
tb/tone_checker.sv
tb/tb_top.sv

// File: hw/key_event_fifo.sv
`include "tone_defines.svh"

`default_nettype none

module key_event_fifo #(
    parameter int DEPTH = `TONE_FIFO_DEPTH
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        wr_valid,
    output logic       wr_ready,
    input  wire  [7:0] wr_code,
    input  wire        wr_release,
    input  wire        wr_extended,
    output logic       rd_valid,
    input  wire        rd_ready,
    output logic [7:0] rd_code,
    output logic       rd_release,
    output logic       rd_extended
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    // entry layout is {extended, release, code}
    logic [9:0]    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    assign {rd_extended, rd_release, rd_code} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_extended, wr_release, wr_code};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CW'(DEPTH));

    // nothing leaves an empty queue
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |=> (rd_ptr == $past(rd_ptr)));

endmodule

`default_nettype wire

// File: hw/keyboard_tone_top.sv
`default_nettype none

module keyboard_tone_top (
    input  wire        clk,
    input  wire        rst,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    output logic       tone,
    output logic [4:0] note,
    output logic       dir_up,
    output logic       fast,
    output logic       frame_error,
    output logic       overflow
);
    // receiver to queue
    logic       ev_valid;
    logic       ev_ready;
    logic [7:0] ev_code;
    logic       ev_release;
    logic       ev_extended;

    // queue to stepper
    logic       q_valid;
    logic       q_ready;
    logic [7:0] q_code;
    logic       q_release;
    logic       q_extended;

    ps2_receiver u_ps2_receiver (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .ev_valid    (ev_valid),
        .ev_code     (ev_code),
        .ev_release  (ev_release),
        .ev_extended (ev_extended),
        .ev_ready    (ev_ready),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    key_event_fifo u_key_event_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_valid    (ev_valid),
        .wr_ready    (ev_ready),
        .wr_code     (ev_code),
        .wr_release  (ev_release),
        .wr_extended (ev_extended),
        .rd_valid    (q_valid),
        .rd_ready    (q_ready),
        .rd_code     (q_code),
        .rd_release  (q_release),
        .rd_extended (q_extended)
    );

    scale_stepper u_scale_stepper (
        .clk        (clk),
        .rst        (rst),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_code     (q_code),
        .q_release  (q_release),
        .q_extended (q_extended),
        .note       (note),
        .dir_up     (dir_up),
        .fast       (fast)
    );

    tone_pwm u_tone_pwm (
        .clk  (clk),
        .rst  (rst),
        .note (note),
        .tone (tone)
    );

endmodule

`default_nettype wire

// File: hw/ps2_receiver.sv
`default_nettype none

module ps2_receiver (
    input  wire        clk,
    input  wire        rst,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    output logic       ev_valid,
    output logic [7:0] ev_code,
    output logic       ev_release,
    output logic       ev_extended,
    input  wire        ev_ready,
    output logic       frame_error,
    output logic       overflow
);
    import tone_pkg::*;

    localparam logic [7:0] CODE_BREAK    = 8'hF0;
    localparam logic [7:0] CODE_EXTENDED = 8'hE0;

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       fall;
    logic       frame_ok;
    ps2_state_e state;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       par_bit;
    logic       rel_flag;
    logic       ext_flag;

    // =========================================================================
    // two-flop synchronizers, both lines idle high
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall = clk_prev && !clk_sync[1];

    // odd parity over data and parity bit, stop bit must be high
    assign frame_ok = (^{shift, par_bit}) && data_sync[1];

    // =========================================================================
    // frame FSM, LSB first
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            bit_cnt     <= '0;
            rel_flag    <= 1'b0;
            ext_flag    <= 1'b0;
            ev_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            ev_valid    <= 1'b0;
            frame_error <= 1'b0;
            if (fall) begin
                case (state)
                    idle: begin
                        if (!data_sync[1]) begin
                            state   <= data;
                            bit_cnt <= '0;
                        end
                    end
                    data: begin
                        shift   <= {data_sync[1], shift[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= parity;
                        end
                    end
                    parity: begin
                        par_bit <= data_sync[1];
                        state   <= stop;
                    end
                    stop: begin
                        state <= idle;
                        if (!frame_ok) begin
                            frame_error <= 1'b1;
                        end else if (shift == CODE_BREAK) begin
                            rel_flag <= 1'b1;
                        end else if (shift == CODE_EXTENDED) begin
                            ext_flag <= 1'b1;
                        end else begin
                            // prefix flags ride along with the data byte
                            ev_valid    <= 1'b1;
                            ev_code     <= shift;
                            ev_release  <= rel_flag;
                            ev_extended <= ext_flag;
                            rel_flag    <= 1'b0;
                            ext_flag    <= 1'b0;
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // keyboard owns the clock, so a full queue means a lost event
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else begin
            overflow <= ev_valid && !ev_ready;
        end
    end

    a_no_event_on_error: assert property (@(posedge clk) disable iff (rst)
        !(ev_valid && frame_error));

endmodule

`default_nettype wire

// File: hw/scale_stepper.sv
`include "tone_defines.svh"

`default_nettype none

module scale_stepper (
    input  wire        clk,
    input  wire        rst,
    input  wire        q_valid,
    output logic       q_ready,
    input  wire  [7:0] q_code,
    input  wire        q_release,
    input  wire        q_extended,
    output logic [4:0] note,
    output logic       dir_up,
    output logic       fast
);
    import tone_pkg::*;

    localparam logic [31:0] PERIOD_SLOW = `TONE_STEP_SLOW;
    localparam logic [31:0] PERIOD_FAST = `TONE_STEP_FAST;
    localparam logic [4:0]  NOTE_LAST   = 5'(`TONE_NOTE_COUNT - 1);

    key_cmd_e    cmd;
    logic        accept;
    logic        restart;
    logic        rate_change;
    logic [31:0] period;
    logic [31:0] timer;
    logic        step_fire;

    // =========================================================================
    // key decode, only plain make codes count
    // =========================================================================
    always_comb begin
        cmd = cmd_none;
        if (!q_release && !q_extended) begin
            case (q_code)
                `KEY_W:     cmd = cmd_up;
                `KEY_S:     cmd = cmd_down;
                `KEY_R:     cmd = cmd_toggle_rate;
                `KEY_ENTER: cmd = cmd_restart;
                default:    cmd = cmd_none;
            endcase
        end
    end

    assign period    = fast ? PERIOD_FAST : PERIOD_SLOW;
    assign step_fire = (timer == period - 32'd1);

    // step and command both write the note, step wins the cycle
    assign q_ready     = !step_fire;
    assign accept      = q_valid && q_ready;
    assign restart     = accept && (cmd == cmd_restart);
    assign rate_change = accept && (cmd == cmd_toggle_rate);

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            dir_up <= 1'b1;
            fast   <= 1'b0;
        end else if (accept) begin
            case (cmd)
                cmd_up:          dir_up <= 1'b1;
                cmd_down:        dir_up <= 1'b0;
                cmd_toggle_rate: fast   <= !fast;
                default:         ;
            endcase
        end
    end

    // =========================================================================
    // step timer and bounded note counter
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst || restart || rate_change || step_fire) begin
            timer <= '0;
        end else begin
            timer <= timer + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            note <= '0;
        end else if (step_fire) begin
            // hold at either end of the scale
            if (dir_up && note != NOTE_LAST) begin
                note <= note + 5'd1;
            end else if (!dir_up && note != 5'd0) begin
                note <= note - 5'd1;
            end
        end
    end

    a_note_range: assert property (@(posedge clk) disable iff (rst)
        note <= NOTE_LAST);

    a_note_step: assert property (@(posedge clk) disable iff (rst)
        (note != $past(note)) |-> ($past(restart) || note == $past(note) + 5'd1
            || note + 5'd1 == $past(note)));

endmodule

`default_nettype wire

// File: hw/tone_defines.svh
`ifndef TONE_DEFINES_SVH
`define TONE_DEFINES_SVH

`default_nettype none

// step timer periods in clock cycles
`define TONE_STEP_SLOW 400
`define TONE_STEP_FAST 200

`define TONE_FIFO_DEPTH 4
`define TONE_NOTE_COUNT 29

// half period of C4, higher notes scale down from it
`define TONE_HALF_BASE 64

// set-2 make codes
`define KEY_W     8'h1D
`define KEY_S     8'h1B
`define KEY_R     8'h2D
`define KEY_ENTER 8'h5A

`default_nettype wire

`endif

// File: hw/tone_pkg.sv
`include "tone_defines.svh"

`default_nettype none

package tone_pkg;

    typedef enum logic [2:0] {
        cmd_none,
        cmd_up,
        cmd_down,
        cmd_toggle_rate,
        cmd_restart
    } key_cmd_e;

    // one state per part of the 11-bit frame, start bit seen in idle
    typedef enum logic [1:0] {
        idle,
        data,
        parity,
        stop
    } ps2_state_e;

    // =========================================================================
    // note index to half period, one octave per 7 notes
    // =========================================================================
    function automatic logic [15:0] note_half_period(input logic [4:0] idx);
        logic [15:0] base;
        case (idx % 5'd7)
            5'd0:    base = 16'(`TONE_HALF_BASE * 262 / 262);
            5'd1:    base = 16'(`TONE_HALF_BASE * 262 / 294);
            5'd2:    base = 16'(`TONE_HALF_BASE * 262 / 330);
            5'd3:    base = 16'(`TONE_HALF_BASE * 262 / 349);
            5'd4:    base = 16'(`TONE_HALF_BASE * 262 / 392);
            5'd5:    base = 16'(`TONE_HALF_BASE * 262 / 440);
            default: base = 16'(`TONE_HALF_BASE * 262 / 494);
        endcase
        // each octave up halves the period
        return base >> (idx / 5'd7);
    endfunction

endpackage

`default_nettype wire

// File: hw/tone_pwm.sv
`default_nettype none

module tone_pwm (
    input  wire       clk,
    input  wire       rst,
    input  wire [4:0] note,
    output logic      tone
);
    import tone_pkg::*;

    logic [15:0] half;
    logic [15:0] cnt;
    logic [4:0]  note_q;

    assign half = note_half_period(note);

    // =========================================================================
    // half-period down counter, toggle at zero
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            tone   <= 1'b0;
            cnt    <= half - 16'd1;
            note_q <= '0;
        end else begin
            note_q <= note;
            if (note != note_q) begin
                // new note, restart the count but keep the level
                cnt <= half - 16'd1;
            end else if (cnt == 16'd0) begin
                tone <= !tone;
                cnt  <= half - 16'd1;
            end else begin
                cnt <= cnt - 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`include "tone_defines.svh"

`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    // 11 bits, 8 system cycles per half bit
    localparam int FRAME_CYCLES = 11 * 16;
    localparam int GAP_MAX      = 1200;
    localparam int RANDOM_KEYS  = 40;
    // a random key may carry a prefix frame, directed and burst keys add the rest
    localparam int MAX_FRAMES   = 2 * RANDOM_KEYS + 20;
    localparam int LIMIT_CYCLES =
        2 * (MAX_FRAMES * (FRAME_CYCLES + GAP_MAX) + 80 * `TONE_STEP_SLOW);

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    wire        tone;
    wire  [4:0] note;
    wire        dir_up;
    wire        fast;
    wire        frame_error;
    wire        overflow;

    logic       exp_push;
    logic [7:0] exp_code;
    logic       exp_release;
    logic       exp_extended;
    logic       done;
    int         bad_sent;
    int         drop_sent;
    int         errors;
    int         checks;
    logic [31:0] rng;

    keyboard_tone_top u_keyboard_tone_top (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .tone        (tone),
        .note        (note),
        .dir_up      (dir_up),
        .fast        (fast),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    tone_checker u_tone_checker (
        .clk          (clk),
        .rst          (rst),
        .note         (note),
        .dir_up       (dir_up),
        .fast         (fast),
        .tone         (tone),
        .frame_error  (frame_error),
        .overflow     (overflow),
        .q_valid      (u_keyboard_tone_top.q_valid),
        .q_ready      (u_keyboard_tone_top.q_ready),
        .q_code       (u_keyboard_tone_top.q_code),
        .q_release    (u_keyboard_tone_top.q_release),
        .q_extended   (u_keyboard_tone_top.q_extended),
        .exp_push     (exp_push),
        .exp_code     (exp_code),
        .exp_release  (exp_release),
        .exp_extended (exp_extended),
        .bad_sent     (bad_sent),
        .drop_sent    (drop_sent),
        .done         (done),
        .errors       (errors),
        .checks       (checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog sized from the worst case of all frames, gaps and step waits
    initial begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: stimulus still running after %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // ========================================================================
    // random source and PS/2 key driver
    // ========================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int next_random();
        rng = xorshift(rng);
        return int'(rng & 32'h7fff_ffff);
    endfunction

    // 1C is a key the stepper does not use
    function automatic logic [7:0] key_for(input int pick);
        case (pick % 5)
            0:       return `KEY_W;
            1:       return `KEY_S;
            2:       return `KEY_R;
            3:       return `KEY_ENTER;
            default: return 8'h1C;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // start, 8 data bits LSB first, odd parity, stop
    task automatic drive_frame(input logic [7:0] code, input logic corrupt);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            wait_cycles(8);
            ps2_clk = 1'b0;
            wait_cycles(8);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic queue_expected(input logic [7:0] code, input logic rel, input logic ext);
        exp_code     = code;
        exp_release  = rel;
        exp_extended = ext;
        exp_push     = 1'b1;
        wait_cycles(1);
        exp_push     = 1'b0;
    endtask

    task automatic press_key(input logic [7:0] code, input logic rel, input logic ext,
                             input logic corrupt, input logic dropped);
        if (ext) begin
            drive_frame(8'hE0, 1'b0);
        end
        if (rel) begin
            drive_frame(8'hF0, 1'b0);
        end
        if (corrupt) begin
            bad_sent++;
        end else if (dropped) begin
            drop_sent++;
        end else begin
            queue_expected(code, rel, ext);
        end
        drive_frame(code, corrupt);
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        logic [7:0] code;
        logic       rel;
        logic       ext;
        logic       bad;
        int         r;
        rst          = 1'b1;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        exp_push     = 1'b0;
        exp_code     = 8'h00;
        exp_release  = 1'b0;
        exp_extended = 1'b0;
        done         = 1'b0;
        bad_sent     = 0;
        drop_sent    = 0;
        rng          = 32'h14ad;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(20);

        // climb to the top note at the fast rate, then all the way down
        press_key(`KEY_ENTER, 1'b0, 1'b0, 1'b0, 1'b0);
        press_key(`KEY_R, 1'b0, 1'b0, 1'b0, 1'b0);
        press_key(`KEY_W, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_cycles(32 * `TONE_STEP_FAST);
        press_key(`KEY_S, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_cycles(32 * `TONE_STEP_FAST);

        // released, extended and corrupted keys must leave the stepper alone
        press_key(`KEY_W, 1'b1, 1'b0, 1'b0, 1'b0);
        press_key(`KEY_W, 1'b0, 1'b1, 1'b0, 1'b0);
        press_key(`KEY_R, 1'b0, 1'b0, 1'b1, 1'b0);
        press_key(`KEY_R, 1'b0, 1'b0, 1'b0, 1'b0);
        press_key(`KEY_W, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_cycles(4 * `TONE_STEP_SLOW);

        for (int k = 0; k < RANDOM_KEYS; k++) begin
            code = key_for(next_random());
            r    = next_random() % 8;
            rel  = (r == 0);
            ext  = (r == 1);
            bad  = (next_random() % 10 == 0);
            if (rel || ext) begin
                bad = 1'b0;
            end
            press_key(code, rel, ext, bad, 1'b0);
            wait_cycles(100 + next_random() % GAP_MAX);
        end

        // back-to-back frames into a blocked stepper overrun the queue
        wait_cycles(20);
        force u_keyboard_tone_top.u_scale_stepper.q_ready = 1'b0;
        for (int k = 0; k < `TONE_FIFO_DEPTH + 2; k++) begin
            press_key(key_for(next_random()), 1'b0, 1'b0, 1'b0, k >= `TONE_FIFO_DEPTH);
        end
        wait_cycles(20);
        release u_keyboard_tone_top.u_scale_stepper.q_ready;
        wait_cycles(4 * `TONE_STEP_SLOW);

        done = 1'b1;
        wait_cycles(3);
        $display("closing: %0d events checked, %0d bad frames, %0d dropped, %0d errors",
                 checks, bad_sent, drop_sent, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tone_checker.sv
`include "tone_defines.svh"

`default_nettype none

module tone_checker (
    input  wire        clk,
    input  wire        rst,
    input  wire  [4:0] note,
    input  wire        dir_up,
    input  wire        fast,
    input  wire        tone,
    input  wire        frame_error,
    input  wire        overflow,
    input  wire        q_valid,
    input  wire        q_ready,
    input  wire  [7:0] q_code,
    input  wire        q_release,
    input  wire        q_extended,
    input  wire        exp_push,
    input  wire  [7:0] exp_code,
    input  wire        exp_release,
    input  wire        exp_extended,
    input  int         bad_sent,
    input  int         drop_sent,
    input  wire        done,
    output int         errors,
    output int         checks
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [4:0] TOP_NOTE = 5'(`TONE_NOTE_COUNT - 1);

    // expected events, {extended, release, code}
    logic [9:0] exp_q[$];
    logic [9:0] head;
    logic [4:0] exp_note;
    logic       exp_dir_up;
    logic       exp_fast;
    logic [4:0] prev_note;
    logic       prev_tone;
    logic       fire;
    logic       closed;
    int         since;
    int         period;
    int         cyc;
    int         last_toggle;
    int         last_change;
    int         quiet_from;
    int         bad_seen;
    int         ovf_seen;

    task automatic log_mismatch(input string name, input int expv, input int actv);
        $display("MISMATCH %0t %s expected %0d actual %0d", $time, name, expv, actv);
        errors++;
    endtask

    task automatic fail_check(input string msg);
        $display("ERROR %0t %s", $time, msg);
        errors++;
    endtask

    // C D E F G A B, one octave per 7 notes, each octave halves the period
    function automatic int expected_half(input int idx);
        int hz;
        case (idx % 7)
            0:       hz = 262;
            1:       hz = 294;
            2:       hz = 330;
            3:       hz = 349;
            4:       hz = 392;
            5:       hz = 440;
            default: hz = 494;
        endcase
        return (`TONE_HALF_BASE * 262 / hz) >> (idx / 7);
    endfunction

    // ========================================================================
    // sampled on the falling edge, away from the DUT's update edge
    // ========================================================================
    always @(negedge clk) begin
        if (exp_push) begin
            exp_q.push_back({exp_extended, exp_release, exp_code});
        end
        if (rst) begin
            exp_note    = 5'd0;
            exp_dir_up  = 1'b1;
            exp_fast    = 1'b0;
            since       = 0;
            prev_note   = 5'd0;
            prev_tone   = 1'b0;
            last_toggle = -1;
            last_change = 0;
            quiet_from  = 0;
            cyc         = 0;
            bad_seen    = 0;
            ovf_seen    = 0;
            closed      = 1'b0;
            errors      = 0;
            checks      = 0;
        end else begin
            cyc++;
            if (note !== exp_note) begin
                log_mismatch("note", int'(exp_note), int'(note));
                exp_note = note;
            end
            if (dir_up !== exp_dir_up) begin
                log_mismatch("dir_up", int'(exp_dir_up), int'(dir_up));
                exp_dir_up = dir_up;
            end
            if (fast !== exp_fast) begin
                log_mismatch("fast", int'(exp_fast), int'(fast));
                exp_fast = fast;
            end
            if (frame_error) begin
                bad_seen++;
            end
            if (overflow) begin
                ovf_seen++;
            end

            // tone interval, only once a whole half period sits inside one note
            if (note != prev_note) begin
                last_change = cyc;
            end
            if (tone != prev_tone) begin
                if (last_toggle > last_change && cyc - last_toggle != expected_half(int'(note)))
                begin
                    log_mismatch("tone half period", expected_half(int'(note)),
                                 cyc - last_toggle);
                end
                last_toggle = cyc;
            end else begin
                // a note change costs one extra cycle before the reload
                quiet_from = (last_toggle > last_change) ? last_toggle : last_change;
                if (cyc - quiet_from == expected_half(int'(note)) + 2) begin
                    fail_check("tone stopped toggling for longer than its half period");
                end
            end
            prev_note = note;
            prev_tone = tone;

            // step point reached after one period at the current rate
            period = exp_fast ? `TONE_STEP_FAST : `TONE_STEP_SLOW;
            fire   = (since == period - 1);
            since  = fire ? 0 : since + 1;
            if (fire && q_ready) begin
                fail_check("stepper took an event on a step cycle");
            end
            if (fire) begin
                if (exp_dir_up && exp_note != TOP_NOTE) begin
                    exp_note = exp_note + 5'd1;
                end else if (!exp_dir_up && exp_note != 5'd0) begin
                    exp_note = exp_note - 5'd1;
                end
            end

            if (q_valid && q_ready) begin
                checks++;
                if (exp_q.size() == 0) begin
                    fail_check("stepper received an event that was never sent");
                end else begin
                    head = exp_q.pop_front();
                    if (q_code !== head[7:0]) begin
                        log_mismatch("q_code", int'(head[7:0]), int'(q_code));
                    end
                    if ({q_extended, q_release} !== head[9:8]) begin
                        log_mismatch("q_extended/q_release", int'(head[9:8]),
                                     int'({q_extended, q_release}));
                    end
                    // only plain make codes are commands
                    if (head[9:8] == 2'b00) begin
                        case (head[7:0])
                            `KEY_W: exp_dir_up = 1'b1;
                            `KEY_S: exp_dir_up = 1'b0;
                            `KEY_R: begin
                                exp_fast = !exp_fast;
                                since    = 0;
                            end
                            `KEY_ENTER: begin
                                exp_note   = 5'd0;
                                exp_dir_up = 1'b1;
                                exp_fast   = 1'b0;
                                since      = 0;
                            end
                            default: ;
                        endcase
                    end
                end
            end

            if (done && !closed) begin
                closed = 1'b1;
                if (exp_q.size() != 0) begin
                    fail_check("events were sent that never reached the stepper");
                end
                if (bad_seen != bad_sent) begin
                    log_mismatch("frame_error pulses", bad_sent, bad_seen);
                end
                if (ovf_seen != drop_sent) begin
                    log_mismatch("overflow pulses", drop_sent, ovf_seen);
                end
            end
        end
    end

endmodule

`default_nettype wire
